// ==== common/l1_pkg.sv ====
`default_nettype none

package l1_pkg;

    // Cache geometry
    localparam int INDEX_W = 9;
    localparam int TAG_W   = 8;
    localparam int LINES   = 512;

    // Word address is byte address bits 18 to 2
    typedef logic [31:0]            word_t;
    typedef logic [TAG_W+INDEX_W-1:0] waddr_t;
    typedef logic [TAG_W-1:0]       tag_t;
    typedef logic [INDEX_W-1:0]     index_t;

    // Zero is a read, all ones a full write, anything else partial
    typedef logic [3:0]             bmask_t;

    // Controller states of the two caches
    typedef enum logic [2:0] {
        DC_IDLE,
        DC_LOOKUP,
        DC_FILL_WRITE,
        DC_MEM_READ,
        DC_MEM_WRITEBACK,
        DC_DONE
    } dcache_state_t;

    typedef enum logic [2:0] {
        IC_IDLE,
        IC_LOOKUP,
        IC_MEM_READ,
        IC_FILL,
        IC_DONE
    } icache_state_t;

endpackage

`default_nettype wire

// ==== data_cache/data_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_cache (
    input  wire                  clk_i,
    input  wire                  rst_i,
    // Core data port
    input  wire                  sel_i,
    input  wire  l1_pkg::waddr_t addr_i,
    input  wire  l1_pkg::bmask_t mask_i,
    input  wire  l1_pkg::word_t  wdata_i,
    output l1_pkg::word_t        rdata_o,
    output logic                 stall_o,
    // Memory request side
    output logic                 mem_valid_o,
    output l1_pkg::waddr_t       mem_addr_o,
    output l1_pkg::word_t        mem_wdata_o,
    output l1_pkg::bmask_t       mem_wstrb_o,
    input  wire  l1_pkg::word_t  mem_rdata_i,
    input  wire                  mem_ready_i
);
    import l1_pkg::*;

    dcache_state_t    state_q;
    dcache_state_t    state_d;
    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;
    logic             from_mem_q;

    index_t index;
    tag_t   tag;
    tag_t   rd_tag;
    word_t  rd_data;
    logic   hit;
    logic   is_write;
    logic   full_write;
    logic   rd_en;
    logic   wr_en;
    word_t  wr_data;
    bmask_t wr_mask;
    word_t  merged;

    word_t  fill_data_q;
    waddr_t wb_addr_q;
    word_t  wb_data_q;

    assign index      = addr_i[INDEX_W-1:0];
    assign tag        = addr_i[INDEX_W +: TAG_W];
    assign is_write   = |mask_i;
    assign full_write = &mask_i;
    assign hit        = valid_q[index] && (rd_tag == tag);

    // Stall follows select and drops only in the completion cycle
    assign stall_o = sel_i && (state_q != DC_DONE);

    assign mem_valid_o = (state_q == DC_MEM_READ) || (state_q == DC_MEM_WRITEBACK);
    assign mem_addr_o  = (state_q == DC_MEM_WRITEBACK) ? wb_addr_q : addr_i;
    assign mem_wdata_o = (state_q == DC_MEM_WRITEBACK) ? wb_data_q : '0;
    assign mem_wstrb_o = (state_q == DC_MEM_WRITEBACK) ? 4'hF : 4'h0;

    // Fetched word with the core's bytes laid over it
    always_comb begin
        merged = mem_rdata_i;
        for (int b = 0; b < 4; b++) begin
            if (mask_i[b]) begin
                merged[8*b +: 8] = wdata_i[8*b +: 8];
            end
        end
    end

    // Re-read after a memory fill so the lookup sees the new line
    assign rd_en   = ((state_q == DC_IDLE) && sel_i) ||
                     ((state_q == DC_FILL_WRITE) && from_mem_q);
    assign wr_en   = (state_q == DC_FILL_WRITE);
    assign wr_data = from_mem_q ? fill_data_q : wdata_i;
    assign wr_mask = from_mem_q ? 4'hF : mask_i;

    cache_store u_store (
        .clk_i      (clk_i),
        .wr_en_i    (wr_en),
        .wr_index_i (index),
        .wr_tag_i   (tag),
        .wr_data_i  (wr_data),
        .wr_mask_i  (wr_mask),
        .rd_en_i    (rd_en),
        .rd_index_i (index),
        .rd_tag_o   (rd_tag),
        .rd_data_o  (rd_data)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            DC_IDLE: begin
                if (sel_i) begin
                    state_d = DC_LOOKUP;
                end
            end
            DC_LOOKUP: begin
                if (hit) begin
                    state_d = is_write ? DC_FILL_WRITE : DC_DONE;
                end else if (valid_q[index] && dirty_q[index]) begin
                    state_d = DC_MEM_WRITEBACK;
                end else if (full_write) begin
                    state_d = DC_FILL_WRITE;
                end else begin
                    state_d = DC_MEM_READ;
                end
            end
            DC_MEM_WRITEBACK: begin
                // Full write needs no fetched word
                if (mem_ready_i) begin
                    state_d = full_write ? DC_FILL_WRITE : DC_MEM_READ;
                end
            end
            DC_MEM_READ: begin
                if (mem_ready_i) begin
                    state_d = DC_FILL_WRITE;
                end
            end
            DC_FILL_WRITE: begin
                state_d = from_mem_q ? DC_LOOKUP : DC_DONE;
            end
            default: begin
                state_d = DC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= DC_IDLE;
            valid_q    <= '0;
            dirty_q    <= '0;
            from_mem_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if ((state_q == DC_MEM_READ) && mem_ready_i) begin
                from_mem_q <= 1'b1;
            end else if (state_q == DC_FILL_WRITE) begin
                from_mem_q <= 1'b0;
            end
            if (wr_en) begin
                valid_q[index] <= 1'b1;
                // Read fills go in clean, merged writes dirty
                dirty_q[index] <= from_mem_q ? is_write : 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == DC_LOOKUP) && (state_d == DC_MEM_WRITEBACK)) begin
            wb_addr_q <= {rd_tag, index};
            wb_data_q <= rd_data;
        end
        if ((state_q == DC_LOOKUP) && hit && !is_write) begin
            rdata_o <= rd_data;
        end
        if ((state_q == DC_MEM_READ) && mem_ready_i) begin
            fill_data_q <= merged;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
common/l1_pkg.sv
hdl/cache_store.sv
data_cache/data_cache.sv
hdl/instr_cache.sv
hdl/mem_arbiter.sv
hdl/l1_subsystem.sv
sim/l1_subsystem_assert.sv
sim/tb_l1_subsystem.sv

// ==== hdl/cache_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_store (
    input  wire                  clk_i,
    input  wire                  wr_en_i,
    input  wire  l1_pkg::index_t wr_index_i,
    input  wire  l1_pkg::tag_t   wr_tag_i,
    input  wire  l1_pkg::word_t  wr_data_i,
    input  wire  l1_pkg::bmask_t wr_mask_i,
    input  wire                  rd_en_i,
    input  wire  l1_pkg::index_t rd_index_i,
    output l1_pkg::tag_t         rd_tag_o,
    output l1_pkg::word_t        rd_data_o
);
    import l1_pkg::*;

    tag_t  tag_mem  [LINES];
    word_t data_mem [LINES];
    word_t wr_merged;

    // Old word with the written bytes laid over it
    always_comb begin
        wr_merged = data_mem[wr_index_i];
        for (int b = 0; b < 4; b++) begin
            if (wr_mask_i[b]) begin
                wr_merged[8*b +: 8] = wr_data_i[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_mem[wr_index_i]  <= wr_tag_i;
            data_mem[wr_index_i] <= wr_merged;
        end
        if (rd_en_i) begin
            // Write-first on a same-index collision so a fill is seen at once
            if (wr_en_i && (wr_index_i == rd_index_i)) begin
                rd_tag_o  <= wr_tag_i;
                rd_data_o <= wr_merged;
            end else begin
                rd_tag_o  <= tag_mem[rd_index_i];
                rd_data_o <= data_mem[rd_index_i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/instr_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_cache (
    input  wire                  clk_i,
    input  wire                  rst_i,
    // Core fetch port
    input  wire                  sel_i,
    input  wire  l1_pkg::waddr_t addr_i,
    output l1_pkg::word_t        rdata_o,
    output logic                 stall_o,
    // Memory request side for reads only
    output logic                 mem_valid_o,
    output l1_pkg::waddr_t       mem_addr_o,
    input  wire  l1_pkg::word_t  mem_rdata_i,
    input  wire                  mem_ready_i
);
    import l1_pkg::*;

    icache_state_t    state_q;
    icache_state_t    state_d;
    logic [LINES-1:0] valid_q;

    index_t index;
    tag_t   tag;
    tag_t   rd_tag;
    word_t  rd_data;
    logic   hit;
    logic   rd_en;
    word_t  fill_data_q;

    assign index = addr_i[INDEX_W-1:0];
    assign tag   = addr_i[INDEX_W +: TAG_W];
    assign hit   = valid_q[index] && (rd_tag == tag);

    assign stall_o     = sel_i && (state_q != IC_DONE);
    assign mem_valid_o = (state_q == IC_MEM_READ);
    assign mem_addr_o  = addr_i;

    assign rd_en = ((state_q == IC_IDLE) && sel_i) || (state_q == IC_FILL);

    cache_store u_store (
        .clk_i      (clk_i),
        .wr_en_i    (state_q == IC_FILL),
        .wr_index_i (index),
        .wr_tag_i   (tag),
        .wr_data_i  (fill_data_q),
        .wr_mask_i  (4'hF),
        .rd_en_i    (rd_en),
        .rd_index_i (index),
        .rd_tag_o   (rd_tag),
        .rd_data_o  (rd_data)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            IC_IDLE:     state_d = sel_i ? IC_LOOKUP : IC_IDLE;
            IC_LOOKUP:   state_d = hit ? IC_DONE : IC_MEM_READ;
            IC_MEM_READ: state_d = mem_ready_i ? IC_FILL : IC_MEM_READ;
            IC_FILL:     state_d = IC_LOOKUP;
            default:     state_d = IC_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IC_IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IC_FILL) begin
                valid_q[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == IC_MEM_READ) && mem_ready_i) begin
            fill_data_q <= mem_rdata_i;
        end
        if ((state_q == IC_LOOKUP) && hit) begin
            rdata_o <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/l1_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_subsystem (
    input  wire                  clk_i,
    input  wire                  rst_i,
    // Core data port
    input  wire                  d_sel_i,
    input  wire  l1_pkg::waddr_t d_addr_i,
    input  wire  l1_pkg::bmask_t d_mask_i,
    input  wire  l1_pkg::word_t  d_wdata_i,
    output l1_pkg::word_t        d_rdata_o,
    output logic                 d_stall_o,
    // Core fetch port
    input  wire                  i_sel_i,
    input  wire  l1_pkg::waddr_t i_addr_i,
    output l1_pkg::word_t        i_rdata_o,
    output logic                 i_stall_o,
    // Main memory
    output logic                 mem_valid_o,
    output l1_pkg::waddr_t       mem_addr_o,
    output l1_pkg::word_t        mem_wdata_o,
    output l1_pkg::bmask_t       mem_wstrb_o,
    input  wire  l1_pkg::word_t  mem_rdata_i,
    input  wire                  mem_ready_i
);
    import l1_pkg::*;

    logic   dc_valid;
    waddr_t dc_addr;
    word_t  dc_wdata;
    bmask_t dc_wstrb;
    logic   dc_ready;
    word_t  dc_rdata;
    logic   ic_valid;
    waddr_t ic_addr;
    logic   ic_ready;
    word_t  ic_rdata;

    data_cache u_data_cache (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .sel_i       (d_sel_i),
        .addr_i      (d_addr_i),
        .mask_i      (d_mask_i),
        .wdata_i     (d_wdata_i),
        .rdata_o     (d_rdata_o),
        .stall_o     (d_stall_o),
        .mem_valid_o (dc_valid),
        .mem_addr_o  (dc_addr),
        .mem_wdata_o (dc_wdata),
        .mem_wstrb_o (dc_wstrb),
        .mem_rdata_i (dc_rdata),
        .mem_ready_i (dc_ready)
    );

    instr_cache u_instr_cache (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .sel_i       (i_sel_i),
        .addr_i      (i_addr_i),
        .rdata_o     (i_rdata_o),
        .stall_o     (i_stall_o),
        .mem_valid_o (ic_valid),
        .mem_addr_o  (ic_addr),
        .mem_rdata_i (ic_rdata),
        .mem_ready_i (ic_ready)
    );

    mem_arbiter u_mem_arbiter (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .d_valid_i   (dc_valid),
        .d_addr_i    (dc_addr),
        .d_wdata_i   (dc_wdata),
        .d_wstrb_i   (dc_wstrb),
        .d_ready_o   (dc_ready),
        .d_rdata_o   (dc_rdata),
        .i_valid_i   (ic_valid),
        .i_addr_i    (ic_addr),
        .i_ready_o   (ic_ready),
        .i_rdata_o   (ic_rdata),
        .mem_valid_o (mem_valid_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wstrb_o (mem_wstrb_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i)
    );

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire                  clk_i,
    input  wire                  rst_i,
    // Data cache requester
    input  wire                  d_valid_i,
    input  wire  l1_pkg::waddr_t d_addr_i,
    input  wire  l1_pkg::word_t  d_wdata_i,
    input  wire  l1_pkg::bmask_t d_wstrb_i,
    output logic                 d_ready_o,
    output l1_pkg::word_t        d_rdata_o,
    // Instruction cache requester
    input  wire                  i_valid_i,
    input  wire  l1_pkg::waddr_t i_addr_i,
    output logic                 i_ready_o,
    output l1_pkg::word_t        i_rdata_o,
    // Main memory
    output logic                 mem_valid_o,
    output l1_pkg::waddr_t       mem_addr_o,
    output l1_pkg::word_t        mem_wdata_o,
    output l1_pkg::bmask_t       mem_wstrb_o,
    input  wire  l1_pkg::word_t  mem_rdata_i,
    input  wire                  mem_ready_i
);
    logic gnt_q;
    logic gnt_d_q;
    logic last_d_q;
    logic to_d;
    logic to_i;

    assign to_d = gnt_q && gnt_d_q;
    assign to_i = gnt_q && !gnt_d_q;

    assign mem_valid_o = (to_d && d_valid_i) || (to_i && i_valid_i);
    assign mem_addr_o  = gnt_d_q ? d_addr_i : i_addr_i;
    // Fetch side never writes
    assign mem_wdata_o = gnt_d_q ? d_wdata_i : '0;
    assign mem_wstrb_o = gnt_d_q ? d_wstrb_i : 4'h0;

    assign d_ready_o = to_d && mem_ready_i;
    assign i_ready_o = to_i && mem_ready_i;
    assign d_rdata_o = to_d ? mem_rdata_i : '0;
    assign i_rdata_o = to_i ? mem_rdata_i : '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gnt_q    <= 1'b0;
            gnt_d_q  <= 1'b0;
            last_d_q <= 1'b0;
        end else if (gnt_q) begin
            // Held until the answer comes back
            if (mem_ready_i) begin
                gnt_q    <= 1'b0;
                last_d_q <= gnt_d_q;
            end
        end else if (d_valid_i || i_valid_i) begin
            gnt_q   <= 1'b1;
            // On a tie, the side not served last wins
            gnt_d_q <= d_valid_i && (!i_valid_i || !last_d_q);
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the L1 subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module tb_l1_subsystem -o sim_l1
./obj_dir/sim_l1 | tee sim.log
if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== sim/l1_subsystem_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_subsystem_assert (
    input wire                 clk_i,
    input wire                 rst_i,
    input wire                 d_sel_i,
    input wire                 d_stall_o,
    input wire                 i_sel_i,
    input wire                 i_stall_o,
    input wire                 mem_valid_o,
    input wire l1_pkg::waddr_t mem_addr_o,
    input wire l1_pkg::word_t  mem_wdata_o,
    input wire l1_pkg::bmask_t mem_wstrb_o,
    input wire                 mem_ready_i
);

    // Out of reset nothing is in flight
    assert property (@(posedge clk_i)
        rst_i |=> (!mem_valid_o && (d_stall_o == d_sel_i) && (i_stall_o == i_sel_i)))
        else $error("Memory valid or stall wrong right after reset");

    // Request held until the ready pulse
    assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_valid_o && !mem_ready_i) |=> (mem_valid_o && $stable(mem_addr_o) &&
                                           $stable(mem_wdata_o) && $stable(mem_wstrb_o)))
        else $error("Memory request changed while waiting for ready");

    assert property (@(posedge clk_i) disable iff (rst_i)
        mem_valid_o |-> ((mem_wstrb_o == 4'h0) || (mem_wstrb_o == 4'hF)))
        else $error("Memory strobe is neither a read nor a full word write");

endmodule

`default_nettype wire

// ==== sim/l1_testdata.txt ====
# port addr mask wdata expected pair (hex, pair is 0 or 1)
# mask 0 reads, expected is ignored on writes; pair 1 issues with the next line
D 00010 0 00000000 A5A50010 0
I 01000 0 00000000 A5A51000 0
D 00010 0 00000000 A5A50010 0
I 01000 0 00000000 A5A51000 0
D 1ABCD 0 00000000 A5A4ABCD 0
I 10234 0 00000000 A5A40234 0
D 00020 F 12345678 00000000 0
D 00020 0 00000000 12345678 0
D 00010 F CAFEF00D 00000000 0
D 00010 0 00000000 CAFEF00D 0
D 00031 3 0000BEEF 00000000 0
D 00031 0 00000000 A5A5BEEF 0
D 00042 C 77880000 00000000 0
D 00042 0 00000000 77880042 0
D 00053 5 00110022 00000000 0
D 00053 0 00000000 A5110022 0
D 00220 0 00000000 A5A50220 0
D 00020 0 00000000 12345678 0
D 00410 F 0BADBEEF 00000000 0
D 00010 0 00000000 CAFEF00D 0
D 00410 0 00000000 0BADBEEF 0
D 10031 8 99000000 00000000 0
D 10031 0 00000000 99A40031 0
D 00031 0 00000000 A5A5BEEF 0
D 00242 0 00000000 A5A50242 0
D 00042 0 00000000 77880042 0
D 00100 0 00000000 A5A50100 1
I 00300 0 00000000 A5A50300 0
D 00053 0 00000000 A5110022 1
I 01000 0 00000000 A5A51000 0
D 00453 0 00000000 A5A50453 1
I 01100 0 00000000 A5A51100 0
D 01234 F 5A5A5A5A 00000000 1
I 1F0F0 0 00000000 A5A4F0F0 0
D 01234 0 00000000 5A5A5A5A 1
I 1F0F0 0 00000000 A5A4F0F0 0
D 00053 0 00000000 A5110022 0

// ==== sim/tb_l1_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_l1_subsystem;
    import l1_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_VEC    = 64;
    localparam int MEM_WORDS  = 1 << (TAG_W + INDEX_W);

    logic   clk_i;
    logic   rst_i;
    logic   d_sel_i;
    waddr_t d_addr_i;
    bmask_t d_mask_i;
    word_t  d_wdata_i;
    word_t  d_rdata_o;
    logic   d_stall_o;
    logic   i_sel_i;
    waddr_t i_addr_i;
    word_t  i_rdata_o;
    logic   i_stall_o;
    logic   mem_valid_o;
    waddr_t mem_addr_o;
    word_t  mem_wdata_o;
    bmask_t mem_wstrb_o;
    word_t  mem_rdata_i;
    logic   mem_ready_i;

    // Main memory and its expected contents once all dirty lines are written back
    word_t  mem_model [MEM_WORDS];
    word_t  exp_mem   [MEM_WORDS];

    // Shadow of the data cache lines for predicting write-backs
    waddr_t line_addr  [LINES];
    logic   line_dirty [LINES];
    logic   wb_pending;
    waddr_t wb_exp_addr;
    word_t  wb_exp_data;

    logic [7:0] vec_port  [MAX_VEC];
    waddr_t     vec_addr  [MAX_VEC];
    bmask_t     vec_mask  [MAX_VEC];
    word_t      vec_wdata [MAX_VEC];
    word_t      vec_exp   [MAX_VEC];
    logic       vec_pair  [MAX_VEC];
    int         num_vec;
    logic       loaded;
    integer     seed;

    l1_subsystem u_l1_subsystem (.*);

    bind l1_subsystem l1_subsystem_assert u_assert (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input waddr_t got, input waddr_t exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %05h expected %05h",
                                        $time, what, got, exp));
        end
    endtask

    // Byte lanes set in the mask come from the new word
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input bmask_t m);
        word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic load_vectors();
        integer     fd;
        integer     n;
        integer     pair;
        string      line;
        logic [7:0] port;
        waddr_t     addr;
        bmask_t     mask;
        word_t      wdata;
        word_t      exp;
        fd = $fopen("sim/l1_testdata.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the test data file sim/l1_testdata.txt");
        end
        num_vec = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines do not match all six columns
            n = $sscanf(line, "%c %h %h %h %h %d", port, addr, mask, wdata, exp, pair);
            if ((n == 6) && (num_vec < MAX_VEC)) begin
                if ((port != "D") && (port != "I")) begin
                    stop_with_failure($sformatf("Unknown port in test data: %s", line));
                end
                vec_port[num_vec]  = port;
                vec_addr[num_vec]  = addr;
                vec_mask[num_vec]  = mask;
                vec_wdata[num_vec] = wdata;
                vec_exp[num_vec]   = exp;
                vec_pair[num_vec]  = (pair != 0);
                num_vec++;
            end
        end
        $fclose(fd);
        if (num_vec == 0) begin
            stop_with_failure("The test data file holds no test lines");
        end
    endtask

    // Index -1 leaves that port idle
    task automatic run_access(input int d_idx, input int i_idx);
        logic   d_busy;
        logic   i_busy;
        logic   d_drop;
        logic   i_drop;
        index_t idx;
        waddr_t addr;
        d_busy = (d_idx >= 0);
        i_busy = (i_idx >= 0);
        if (d_busy) begin
            addr        = vec_addr[d_idx];
            idx         = addr[INDEX_W-1:0];
            wb_exp_addr = line_addr[idx];
            wb_exp_data = exp_mem[line_addr[idx]];
            wb_pending  = line_dirty[idx] && (line_addr[idx] != addr);
            if (vec_mask[d_idx] != 4'h0) begin
                exp_mem[addr]   = merge_bytes(exp_mem[addr], vec_wdata[d_idx], vec_mask[d_idx]);
                line_dirty[idx] = 1'b1;
            end else if (line_addr[idx] != addr) begin
                line_dirty[idx] = 1'b0;
            end
            line_addr[idx] = addr;
        end
        @(posedge clk_i);
        if (d_busy) begin
            d_sel_i   <= 1'b1;
            d_addr_i  <= vec_addr[d_idx];
            d_mask_i  <= vec_mask[d_idx];
            d_wdata_i <= vec_wdata[d_idx];
        end
        if (i_busy) begin
            i_sel_i  <= 1'b1;
            i_addr_i <= vec_addr[i_idx];
        end
        while (d_busy || i_busy) begin
            @(negedge clk_i);
            d_drop = d_busy && !d_stall_o;
            i_drop = i_busy && !i_stall_o;
            if (d_drop) begin
                if (vec_mask[d_idx] == 4'h0) begin
                    check_word(d_rdata_o, vec_exp[d_idx],
                               $sformatf("data read of %05h", vec_addr[d_idx]));
                end
                if (wb_pending) begin
                    stop_with_failure($sformatf("Expected write-back of %05h never reached memory",
                                                wb_exp_addr));
                end
                d_busy = 1'b0;
            end
            if (i_drop) begin
                check_word(i_rdata_o, vec_exp[i_idx],
                           $sformatf("fetch of %05h", vec_addr[i_idx]));
                i_busy = 1'b0;
            end
            @(posedge clk_i);
            if (d_drop) begin
                d_sel_i <= 1'b0;
            end
            if (i_drop) begin
                i_sel_i <= 1'b0;
            end
        end
    endtask

    // Main memory model answering each request after 0 to 3 wait cycles
    initial begin
        int     wait_cycles;
        waddr_t req_addr;
        word_t  req_wdata;
        bmask_t req_strb;
        forever begin
            @(negedge clk_i);
            if (mem_valid_o) begin
                req_addr    = mem_addr_o;
                req_wdata   = mem_wdata_o;
                req_strb    = mem_wstrb_o;
                wait_cycles = {$random(seed)} % 4;
                repeat (wait_cycles) @(negedge clk_i);
                @(posedge clk_i);
                if (req_strb == 4'hF) begin
                    if (!wb_pending) begin
                        stop_with_failure($sformatf("Unexpected memory write to %05h", req_addr));
                    end
                    check_addr(req_addr, wb_exp_addr, "write-back address");
                    check_word(req_wdata, wb_exp_data, "write-back data");
                    wb_pending          = 1'b0;
                    mem_model[req_addr] = req_wdata;
                end
                mem_ready_i <= 1'b1;
                mem_rdata_i <= mem_model[req_addr];
                @(posedge clk_i);
                mem_ready_i <= 1'b0;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (num_vec * 60) @(posedge clk_i);
        stop_with_failure($sformatf("Timeout after %0d cycles, the tests did not finish",
                                    num_vec * 60));
    end

    initial begin
        int i;
        seed        = 32'h54ed_e46e;
        rst_i       = 1'b1;
        d_sel_i     = 1'b0;
        d_addr_i    = '0;
        d_mask_i    = '0;
        d_wdata_i   = '0;
        i_sel_i     = 1'b0;
        i_addr_i    = '0;
        mem_rdata_i = '0;
        mem_ready_i = 1'b0;
        wb_pending  = 1'b0;
        loaded      = 1'b0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem_model[a] = word_t'(a) ^ 32'hA5A5_0000;
            exp_mem[a]   = mem_model[a];
        end
        for (int l = 0; l < LINES; l++) begin
            line_addr[l]  = '0;
            line_dirty[l] = 1'b0;
        end
        load_vectors();
        loaded = 1'b1;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        i = 0;
        while (i < num_vec) begin
            if (vec_pair[i] && (i + 1 < num_vec)) begin
                if (vec_port[i] == vec_port[i+1]) begin
                    stop_with_failure($sformatf("Paired test lines %0d and %0d use one port",
                                                i, i + 1));
                end
                if (vec_port[i] == "D") begin
                    run_access(i, i + 1);
                end else begin
                    run_access(i + 1, i);
                end
                i += 2;
            end else begin
                if (vec_port[i] == "D") begin
                    run_access(i, -1);
                end else begin
                    run_access(-1, i);
                end
                i++;
            end
        end
        repeat (2) @(posedge clk_i);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
